// ==== fetch_pkg.sv ====
package fetch_pkg;

    // basic widths
    typedef logic [31:0] word_t;        // instruction or data word
    typedef logic [7:0]  byte_t;        // one byte from the serial link
    typedef logic [31:0] pc_t;          // byte address of the fetch

    // loader word address, msb picks the target memory
    typedef logic [15:0] load_addr_t;

    localparam int LOAD_SEL_BIT = 15;   // 0 = instruction mem, 1 = data mem

    // one memory write from the loader
    typedef struct packed {
        logic       en;                 // write strobe
        load_addr_t addr;               // word address, low bits used
        word_t      data;               // assembled word
    } mem_wr_t;

    // redirect request from the later stages
    typedef struct packed {
        logic  branch_en;               // pc relative branch
        word_t branch_offset;           // offset in words
        logic  jump_en;                 // absolute jump
        pc_t   jump_target;             // byte address
    } redirect_t;

    // what fetch hands to the decode register
    typedef struct packed {
        pc_t   pc;                      // address of instruction
        pc_t   pc_plus4;                // sequential successor
        word_t instruction;             // rom word at pc
        logic  no_op;                   // bubble, decode ignores it
    } fetch_out_t;

endpackage

// ==== inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 10        // log2 of word count
) (
    input  logic                 clk,
    input  mem_wr_t              wr,        // loader write port
    input  logic                 rd_en,     // low while fetch is held
    input  logic [ROM_DEPTH-1:0] rd_addr,   // word address
    output word_t                rd_data
);

    localparam int WORDS = 2 ** ROM_DEPTH;

    word_t mem [WORDS];                 // block ram style array

    // loader side
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[ROM_DEPTH-1:0]] <= wr.data;   // low bits only
        end
    end

    // fetch side, registered read
    // output keeps the last word when the read is disabled, so a held
    // fetch keeps presenting the same instruction
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 10        // log2 of word count
) (
    input  logic                 clk,
    input  mem_wr_t              wr,        // loader write port
    input  logic [ROM_DEPTH-1:0] rd_addr,   // core load address, words
    output word_t                rd_data    // valid one cycle later
);

    localparam int WORDS = 2 ** ROM_DEPTH;

    word_t mem [WORDS];                 // same style as the rom

    // loader fills the data image
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[ROM_DEPTH-1:0]] <= wr.data;   // bit 15 already decoded
        end
    end

    // core load path, read every cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== prog_loader.sv ====
`timescale 1ns/1ps

module prog_loader
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 10        // log2 of words per memory
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    byte_valid,         // one byte per strobe
    input  byte_t   byte_data,
    input  logic    load_start,         // clears state and opens a load
    input  logic    load_end,           // closes the load
    output mem_wr_t imem_wr,
    output mem_wr_t dmem_wr,
    output logic    load_busy,          // hazard for fetch
    output logic    pc_restart          // one cycle pulse as busy falls
);

    typedef enum logic {
        idle,
        loading
    } load_state_t;

    load_state_t state;
    logic [1:0]  byte_cnt;              // bytes in the current word
    word_t       shift_q;               // partial word filled lsb first
    load_addr_t  word_addr;             // next word address
    logic        imem_en;
    logic        dmem_en;
    load_addr_t  wr_addr;               // payload of the pending write
    word_t       wr_data;
    logic        restart_q;
    logic        byte_take;
    logic        word_done;
    logic        in_range;
    word_t       word_next;

    // a fresh load_start wins over anything else in that cycle
    assign byte_take = (state == loading) && byte_valid && !load_start;
    assign word_done = byte_take && (byte_cnt == 2'd3);     // fourth byte
    assign word_next = {byte_data, shift_q[31:8]};          // new byte enters at top

    // words past the memory size are dropped instead of aliasing onto low words
    assign in_range = ((word_addr[LOAD_SEL_BIT-1:0] >> ROM_DEPTH) == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            byte_cnt  <= '0;
            word_addr <= '0;
            imem_en   <= 1'b0;
            dmem_en   <= 1'b0;
            restart_q <= 1'b0;
        end else begin
            imem_en   <= word_done && in_range && !word_addr[LOAD_SEL_BIT];  // lower half
            dmem_en   <= word_done && in_range && word_addr[LOAD_SEL_BIT];   // upper half
            restart_q <= (state == loading) && load_end && !load_start;
            if (load_start) begin
                state     <= loading;
                byte_cnt  <= '0;        // realign to a word boundary
                word_addr <= '0;
            end else if (state == loading) begin
                if (byte_valid) begin
                    byte_cnt <= byte_cnt + 2'd1;    // wraps after four
                end
                if (word_done) begin
                    word_addr <= word_addr + 16'd1;
                end
                if (load_end) begin
                    state <= idle;
                end
            end
        end
    end

    // word assembly and write payload
    always_ff @(posedge clk) begin
        if (byte_take) begin
            shift_q <= word_next;
        end
        if (word_done) begin
            wr_addr <= word_addr;       // address before the increment
            wr_data <= word_next;
        end
    end

    assign imem_wr.en   = imem_en;
    assign imem_wr.addr = wr_addr;
    assign imem_wr.data = wr_data;

    assign dmem_wr.en   = dmem_en;
    assign dmem_wr.addr = wr_addr;
    assign dmem_wr.data = wr_data;

    assign load_busy  = (state == loading);     // high from cycle after start
    assign pc_restart = restart_q;              // lines up with busy falling

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 10        // log2 of rom words
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  redirect_t            redirect,      // from later stages
    input  logic                 stall,         // pipeline hold
    input  logic                 load_busy,     // loader hazard
    input  logic                 pc_restart,    // load finished
    output logic                 rom_en,
    output logic [ROM_DEPTH-1:0] rom_addr,
    input  word_t                rom_data,      // word at pc, same cycle
    output fetch_out_t           fetch
);

    pc_t  pc_q;
    pc_t  pc_plus4_q;
    pc_t  seq_pc;                       // pc picked from redirect
    pc_t  next_pc;                      // pc after restart override
    logic no_op_q;
    logic hold;
    logic restart;

    assign hold = stall | load_busy;

    // reset primes the rom with word 0 just like a load restart
    assign restart = pc_restart | !rst_n;

    // next pc select, both enables together fall back to sequential
    always_comb begin
        case ({redirect.branch_en, redirect.jump_en})
            2'b10:   seq_pc = pc_plus4_q + (redirect.branch_offset << 2);  // offset in words
            2'b01:   seq_pc = redirect.jump_target;
            default: seq_pc = pc_plus4_q;
        endcase
    end

    assign next_pc = restart ? '0 : seq_pc;

    // rom is fed the next pc, so its registered output matches pc_q
    assign rom_en   = restart | !hold;          // off while frozen
    assign rom_addr = next_pc[ROM_DEPTH+1:2];   // byte to word address

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q       <= '0;
            pc_plus4_q <= 32'd4;
            no_op_q    <= 1'b0;
        end else if (pc_restart) begin
            pc_q       <= '0;                   // start of new program
            pc_plus4_q <= 32'd4;
            no_op_q    <= 1'b0;
        end else if (!hold) begin
            pc_q       <= next_pc;
            pc_plus4_q <= next_pc + 32'd4;
            no_op_q    <= 1'b0;                 // clears on first free cycle
        end else begin
            no_op_q    <= 1'b1;                 // frozen, mark bubble
        end
    end

    assign fetch.pc          = pc_q;
    assign fetch.pc_plus4    = pc_plus4_q;
    assign fetch.instruction = rom_data;        // held by the rom on hold
    assign fetch.no_op       = no_op_q;

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 10        // passed to every block
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 byte_valid,    // loader byte strobe
    input  byte_t                byte_data,
    input  logic                 load_start,
    input  logic                 load_end,
    input  logic                 stall,
    input  redirect_t            redirect,
    input  logic [ROM_DEPTH-1:0] dmem_raddr,    // core load address
    output word_t                dmem_rdata,
    output fetch_out_t           fetch
);

    mem_wr_t              imem_wr;
    mem_wr_t              dmem_wr;
    logic                 load_busy;
    logic                 pc_restart;
    logic                 rom_en;
    logic [ROM_DEPTH-1:0] rom_addr;
    word_t                rom_data;

    prog_loader #(.ROM_DEPTH(ROM_DEPTH)) u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .load_start (load_start),
        .load_end   (load_end),
        .imem_wr    (imem_wr),
        .dmem_wr    (dmem_wr),
        .load_busy  (load_busy),
        .pc_restart (pc_restart)
    );

    fetch_stage #(.ROM_DEPTH(ROM_DEPTH)) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .stall      (stall),
        .load_busy  (load_busy),
        .pc_restart (pc_restart),
        .rom_en     (rom_en),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .fetch      (fetch)
    );

    inst_rom #(.ROM_DEPTH(ROM_DEPTH)) u_rom (
        .clk     (clk),
        .wr      (imem_wr),
        .rd_en   (rom_en),
        .rd_addr (rom_addr),
        .rd_data (rom_data)
    );

    data_ram #(.ROM_DEPTH(ROM_DEPTH)) u_ram (
        .clk     (clk),
        .wr      (dmem_wr),
        .rd_addr (dmem_raddr),
        .rd_data (dmem_rdata)
    );

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
;

    localparam int ROM_DEPTH    = 10;
    localparam int CLK_PERIOD   = 4;                        // ns
    localparam int IMEM_WORDS   = 2 ** ROM_DEPTH;
    localparam int DATA_BASE    = 32768;                    // bit 15 set
    localparam int DATA_WORDS   = 4;
    localparam int IMG_WORDS    = DATA_BASE + DATA_WORDS;
    localparam int HAZARD_WORDS = 16;
    localparam int WAIT_LIMIT   = 64;                       // cycles for a handshake
    localparam int SEQ_CYCLES   = 64;

    // cycle budgets per test summed for the watchdog
    localparam int LOAD_BUDGET   = IMG_WORDS * 4 + SEQ_CYCLES + 2 * WAIT_LIMIT;
    localparam int BRANCH_BUDGET = 8 * 8;
    localparam int JUMP_BUDGET   = 8 * 10;
    localparam int HOLD_BUDGET   = 24;
    localparam int DATA_BUDGET   = DATA_WORDS * 4;
    localparam int HAZARD_BUDGET = HAZARD_WORDS * 4 + 3 * WAIT_LIMIT + 24;
    localparam int TOTAL_BUDGET  = 16 + LOAD_BUDGET + BRANCH_BUDGET + JUMP_BUDGET
                                 + HOLD_BUDGET + DATA_BUDGET + HAZARD_BUDGET;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 byte_valid;
    byte_t                byte_data;
    logic                 load_start;
    logic                 load_end;
    logic                 stall;
    redirect_t            redirect;
    logic [ROM_DEPTH-1:0] dmem_raddr;
    word_t                dmem_rdata;
    fetch_out_t           fetch;

    word_t imem_mirror [IMEM_WORDS];    // expected rom image
    word_t dmem_mirror [DATA_WORDS];    // expected data words
    word_t rng = 32'hbbae0d3e;          // xorshift state
    pc_t   last_pc = '0;                // pc of the last full fetch check
    string cur_test = "reset";
    int    errors = 0;
    int    errors_at_start = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    fetch_top #(.ROM_DEPTH(ROM_DEPTH)) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .load_start (load_start),
        .load_end   (load_end),
        .stall      (stall),
        .redirect   (redirect),
        .dmem_raddr (dmem_raddr),
        .dmem_rdata (dmem_rdata),
        .fetch      (fetch)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // sequential successor always tracks pc
    assert property (@(posedge clk) disable iff (!rst_n)
            fetch.pc_plus4 == fetch.pc + 32'd4)
        else begin
            $display("CHECK FAILED %s pc_plus4 expected %h actual %h", cur_test,
                     $sampled(fetch.pc) + 32'd4, $sampled(fetch.pc_plus4));
            errors++;
        end

    // a held cycle freezes pc and marks the bubble on the next edge
    assert property (@(posedge clk) disable iff (!rst_n)
            ((stall || dut.load_busy) && !dut.pc_restart)
            |=> ($stable(fetch.pc) && fetch.no_op))
        else begin
            $display("%s: pc moved or no_op stayed low during a held cycle", cur_test);
            errors++;
        end

    // rom read is disabled on stall so the word stays put
    assert property (@(posedge clk) disable iff (!rst_n)
            (stall && !dut.pc_restart) |=> $stable(fetch.instruction))
        else begin
            $display("%s: instruction changed while stalled", cur_test);
            errors++;
        end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string test, input string what,
                               input word_t expected, input word_t actual);
        assert (expected == actual)
            else begin
                $display("CHECK FAILED %s %s expected %h actual %h",
                         test, what, expected, actual);
                errors++;
            end
    endtask

    // full fetch output for an expected pc with no bubble
    task automatic check_fetch(input string test, input pc_t exp_pc);
        check_value(test, "pc", exp_pc, fetch.pc);
        check_value(test, "pc_plus4", exp_pc + 32'd4, fetch.pc_plus4);
        check_value(test, "instruction", imem_mirror[exp_pc[ROM_DEPTH+1:2]],
                    fetch.instruction);
        check_value(test, "no_op", 32'd0, {31'd0, fetch.no_op});
        last_pc = exp_pc;
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // load_start then bytes lsb first then load_end
    task automatic upload(input word_t words[$]);
        @(posedge clk);
        load_start <= 1'b1;
        @(posedge clk);
        load_start <= 1'b0;
        foreach (words[i]) begin
            for (int b = 0; b < 4; b++) begin
                byte_valid <= 1'b1;
                byte_data  <= words[i][8*b +: 8];
                @(posedge clk);
            end
        end
        byte_valid <= 1'b0;
        @(posedge clk);                 // last word lands in memory
        load_end <= 1'b1;
        @(posedge clk);
        load_end <= 1'b0;
    endtask

    // leaves right after the first negedge with a live fetch
    task automatic wait_fetch_valid(input string test);
        int n;
        n = 0;
        @(negedge clk);
        while (fetch.no_op || dut.load_busy) begin
            if (n == WAIT_LIMIT) begin
                $display("%s: fetch did not resume after the load", test);
                errors++;
                return;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic run_sequential(input string test, input int cycles);
        pc_t prev;
        prev = last_pc;                 // pc checked at this negedge
        repeat (cycles) begin
            @(negedge clk);
            check_fetch(test, prev + 32'd4);
            prev = prev + 32'd4;
        end
    endtask

    task automatic watch_frozen_pc(input string test);
        pc_t held;
        int  n;
        n = 0;
        @(negedge clk);
        while (!dut.load_busy) begin
            if (n == WAIT_LIMIT) begin
                $display("%s: loader never reported busy", test);
                errors++;
                return;
            end
            n++;
            @(negedge clk);
        end
        held = fetch.pc;                // frozen from here on
        while (dut.load_busy) begin
            check_value(test, "pc during load", held, fetch.pc);
            @(negedge clk);
        end
    endtask

    task automatic load_and_run();
        word_t image[$];
        begin_test("load_sequential");
        for (int a = 0; a < IMG_WORDS; a++) begin
            if (a < IMEM_WORDS) begin
                rng = xorshift(rng);
                imem_mirror[a] = rng;
                image.push_back(rng);
            end else if (a < DATA_BASE) begin
                image.push_back({~a[15:0], a[15:0]});   // out of range so the loader drops it
            end else begin
                rng = xorshift(rng);
                dmem_mirror[a - DATA_BASE] = rng;
                image.push_back(rng);
            end
        end
        upload(image);
        wait_fetch_valid(cur_test);
        check_fetch(cur_test, 32'd0);   // restart at zero
        run_sequential(cur_test, SEQ_CYCLES);
        end_test();
    endtask

    task automatic branch_redirect();
        word_t off;
        pc_t   p4;
        begin_test("branch");
        repeat (8) begin
            rng = xorshift(rng);
            off = {{27{rng[4]}}, rng[4:0]};             // -16 .. 15 words
            @(posedge clk);
            redirect.branch_en     <= 1'b1;
            redirect.branch_offset <= off;
            @(negedge clk);
            check_fetch(cur_test, last_pc + 32'd4);     // step before the branch edge
            p4 = last_pc + 32'd4;       // value seen by the branch edge
            @(posedge clk);
            redirect.branch_en <= 1'b0;
            @(negedge clk);
            check_fetch(cur_test, p4 + off * 32'd4);
            run_sequential(cur_test, 2);
        end
        end_test();
    endtask

    task automatic jump_priority();
        pc_t target;
        pc_t p4;
        begin_test("jump_priority");
        repeat (4) begin
            rng = xorshift(rng);
            target = {rng[31:2], 2'b00};
            @(posedge clk);
            redirect.jump_en     <= 1'b1;
            redirect.jump_target <= target;
            @(posedge clk);
            redirect.jump_en <= 1'b0;
            @(negedge clk);
            check_fetch(cur_test, target);
            run_sequential(cur_test, 2);
        end
        repeat (4) begin
            rng = xorshift(rng);
            @(posedge clk);
            redirect.branch_en     <= 1'b1;             // both set means sequential
            redirect.branch_offset <= {24'd0, rng[7:0]};
            redirect.jump_en       <= 1'b1;
            redirect.jump_target   <= {rng[31:2], 2'b00};
            @(negedge clk);
            check_fetch(cur_test, last_pc + 32'd4);
            p4 = last_pc + 32'd4;
            @(posedge clk);
            redirect <= '0;
            @(negedge clk);
            check_fetch(cur_test, p4);
            run_sequential(cur_test, 2);
        end
        end_test();
    endtask

    task automatic stall_hold();
        pc_t held;
        begin_test("hold");
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        held = fetch.pc;
        repeat (5) begin
            @(negedge clk);
            check_value(cur_test, "held pc", held, fetch.pc);
            check_value(cur_test, "held instruction", imem_mirror[held[ROM_DEPTH+1:2]],
                        fetch.instruction);
            check_value(cur_test, "no_op", 32'd1, {31'd0, fetch.no_op});
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_value(cur_test, "no_op", 32'd1, {31'd0, fetch.no_op});  // last held edge
        @(negedge clk);
        check_fetch(cur_test, held + 32'd4);
        run_sequential(cur_test, 4);
        end_test();
    endtask

    task automatic data_routing();
        begin_test("data_routing");
        for (int i = 0; i < DATA_WORDS; i++) begin
            @(posedge clk);
            dmem_raddr <= i[ROM_DEPTH-1:0];
            @(posedge clk);             // address sampled and data registered
            @(negedge clk);
            check_value(cur_test, "dmem_rdata", dmem_mirror[i], dmem_rdata);
        end
        end_test();
    endtask

    task automatic load_hazard();
        word_t prog[$];
        begin_test("load_hazard");
        for (int i = 0; i < HAZARD_WORDS; i++) begin
            rng = xorshift(rng);
            imem_mirror[i] = rng;       // overwrites the low program words
            prog.push_back(rng);
        end
        fork
            upload(prog);
            watch_frozen_pc(cur_test);
        join
        wait_fetch_valid(cur_test);
        check_fetch(cur_test, 32'd0);
        run_sequential(cur_test, 20);
        end_test();
    endtask

    initial begin
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = '0;
        load_start = 1'b0;
        load_end   = 1'b0;
        stall      = 1'b0;
        redirect   = '0;
        dmem_raddr = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        load_and_run();
        branch_redirect();
        jump_priority();
        stall_hold();
        data_routing();
        load_hazard();

        repeat (2) @(negedge clk);      // let pending property attempts settle
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TOTAL_BUDGET * 4 * CLK_PERIOD);
        $display("timeout, the tests did not finish within their cycle budget");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
fetch_pkg.sv
inst_rom.sv
data_ram.sv
prog_loader.sv
fetch_stage.sv
fetch_top.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fetch -f list.f -o tb_fetch_sim

./obj_dir/tb_fetch_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
